// File: common/busPkg.sv
`default_nettype none

package busPkg;

    // Word address bus a[31:1]
    localparam int addrW = 31;

    // Memory space of one transfer
    // Codes are fixed so stimulus files can name them by number
    typedef enum logic [2:0] {
        spNone = 3'd0,
        spChip = 3'd1,
        spReg  = 3'd2,
        spCia  = 3'd3,
        spRom  = 3'd4,
        spAvec = 3'd5
    } spaceT;

    // 040 transfer type for interrupt acknowledge
    localparam logic [1:0] ttIack = 2'd3;

    //////////////////////////////////////////////////////////////////////
    // Byte address map
    //////////////////////////////////////////////////////////////////////

    // Upper byte set means off the 24-bit map
    localparam logic [31:0] upperMask = 32'hFF00_0000;
    // Chip RAM below this
    localparam logic [31:0] chipTop   = 32'h0020_0000;
    // ROM overlay window while ovl is high
    localparam logic [31:0] ovlTop    = 32'h0008_0000;
    // CIA page 0xBFxxxx
    localparam logic [31:0] ciaBase   = 32'h00BF_0000;
    localparam logic [31:0] ciaMask   = 32'h00FF_0000;
    // Custom registers, one 4 KB page
    localparam logic [31:0] regBase   = 32'h00DF_F000;
    localparam logic [31:0] regMask   = 32'h00FF_F000;
    // Boot ROM up to the top of the map
    localparam logic [31:0] romBase   = 32'h00F8_0000;

endpackage

`default_nettype wire

// File: common/timingPkg.sv
`default_nettype none

package timingPkg;

    // Wait-state and phase counters
    localparam int cntW = 16;
    // Tick dividers need more range at 40 MHz
    localparam int tickW = 20;

    // Wait cycles after the select cycle
    localparam int romWaitDef    = 3;
    localparam int chipWaitDef   = 5;
    // Cycles until bus error on an unknown space
    localparam int busTimeoutDef = 64;

    // E-clock phase lengths in clk40 cycles
    localparam int ciaHighDef = 4;
    localparam int ciaLowDef  = 6;

    // Tick half-periods for 60 Hz and 50 Hz from 40 MHz
    localparam int tick60Def = 333_333;
    localparam int tick50Def = 400_000;

endpackage

`default_nettype wire

// File: decode/addressDecode.sv
`timescale 1ns/100ps
`default_nettype none

module addressDecode (
    input  logic                   clk40,
    input  logic                   rstN,
    input  logic                   tsN,
    input  logic [busPkg::addrW:1] a,
    input  logic [1:0]             tt,
    input  logic                   lbenN,
    input  logic                   ovl,
    input  logic                   done,
    output busPkg::spaceT          space,
    output logic                   cycleActive,
    output logic                   romEnN,
    output logic                   ramSpaceN,
    output logic                   regSpaceN,
    output logic                   ciaCs0N,
    output logic                   ciaCs1N,
    output logic                   bufEnN,
    output logic                   portSize
);

    logic [31:0]   byteAddr;
    busPkg::spaceT nextSpace;
    logic          startCycle;
    logic          endCycle;

    //////////////////////////////////////////////////////////////////////
    // Space classification
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // Bit 0 is implied by the word bus
        byteAddr = {a, 1'b0};

        // Non-local cycle, someone else answers
        if (lbenN) begin
            nextSpace = busPkg::spNone;
        // IACK wins over any address
        end else if (tt == busPkg::ttIack) begin
            nextSpace = busPkg::spAvec;
        end else if ((byteAddr & busPkg::upperMask) != '0) begin
            nextSpace = busPkg::spNone;
        end else if (byteAddr < busPkg::chipTop) begin
            // Overlay maps ROM over low chip RAM after reset
            if (ovl && (byteAddr < busPkg::ovlTop)) begin
                nextSpace = busPkg::spRom;
            end else begin
                nextSpace = busPkg::spChip;
            end
        end else if ((byteAddr & busPkg::ciaMask) == busPkg::ciaBase) begin
            nextSpace = busPkg::spCia;
        end else if ((byteAddr & busPkg::regMask) == busPkg::regBase) begin
            nextSpace = busPkg::spReg;
        end else if (byteAddr >= busPkg::romBase) begin
            nextSpace = busPkg::spRom;
        end else begin
            nextSpace = busPkg::spNone;
        end
    end

    // Strobes inside an active cycle are ignored
    assign startCycle = !cycleActive && !tsN;
    // Ack or error seen, drop selects next edge
    assign endCycle   = cycleActive && done;

    //////////////////////////////////////////////////////////////////////
    // Held cycle state and selects
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk40) begin
        if (!rstN || endCycle) begin
            cycleActive <= 1'b0;
            space       <= busPkg::spNone;
            romEnN      <= 1'b1;
            ramSpaceN   <= 1'b1;
            regSpaceN   <= 1'b1;
            ciaCs0N     <= 1'b1;
            ciaCs1N     <= 1'b1;
            bufEnN      <= 1'b1;
            portSize    <= 1'b0;
        end else if (startCycle) begin
            cycleActive <= 1'b1;
            space       <= nextSpace;
            romEnN      <= nextSpace != busPkg::spRom;
            ramSpaceN   <= nextSpace != busPkg::spChip;
            regSpaceN   <= nextSpace != busPkg::spReg;
            // CIA-A on A12 low, CIA-B on A13 low
            ciaCs0N     <= !((nextSpace == busPkg::spCia) && !a[12]);
            ciaCs1N     <= !((nextSpace == busPkg::spCia) && !a[13]);
            // Data buffers only face the chip bus
            bufEnN      <= !((nextSpace == busPkg::spChip) || (nextSpace == busPkg::spReg));
            // Narrow port for CIA and custom regs
            portSize    <= (nextSpace == busPkg::spCia) || (nextSpace == busPkg::spReg);
        end
    end

endmodule

`default_nettype wire

// File: logic/transferAck.sv
`timescale 1ns/100ps
`default_nettype none

module transferAck #(
    parameter int romWait    = timingPkg::romWaitDef,
    parameter int chipWait   = timingPkg::chipWaitDef,
    parameter int busTimeout = timingPkg::busTimeoutDef
) (
    input  logic          clk40,
    input  logic          rstN,
    input  busPkg::spaceT space,
    input  logic          cycleActive,
    input  logic          ciaStrobe,
    output logic          tackN,
    output logic          teaN,
    output logic          done
);

    localparam int cw = timingPkg::cntW;

    logic          activeQ;
    logic          rise;
    logic          waiting;
    logic          isCia;
    logic          ciaHit;
    logic          fixedFire;
    logic          ackQ;
    logic          errQ;
    logic [cw-1:0] count;
    logic [cw-1:0] loadVal;

    // Wait length per held space
    always_comb begin
        case (space)
            busPkg::spAvec: loadVal = '0;
            busPkg::spRom:  loadVal = cw'(romWait);
            busPkg::spChip: loadVal = cw'(chipWait);
            busPkg::spReg:  loadVal = cw'(chipWait);
            // Holdoff of one cycle before a strobe may count
            busPkg::spCia:  loadVal = cw'(1);
            default:        loadVal = cw'(busTimeout - 1);
        endcase
    end

    assign isCia = space == busPkg::spCia;
    // First cycle of a new transfer
    assign rise  = cycleActive && !activeQ;

    // Zero wait fires straight from the rise cycle
    assign fixedFire = !isCia && ((rise && (loadVal == '0)) || (waiting && (count == cw'(1))));

    // CIA ends on the E-clock strobe itself
    assign ciaHit = isCia && waiting && (count == '0) && ciaStrobe;

    //////////////////////////////////////////////////////////////////////
    // Wait-state counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk40) begin
        if (!rstN) begin
            activeQ <= 1'b0;
            waiting <= 1'b0;
            count   <= '0;
            ackQ    <= 1'b0;
            errQ    <= 1'b0;
        end else begin
            activeQ <= cycleActive;
            ackQ    <= fixedFire && (space != busPkg::spNone);
            // Unknown space times out into a bus error
            errQ    <= fixedFire && (space == busPkg::spNone);
            if (fixedFire || ciaHit) begin
                waiting <= 1'b0;
            end else if (rise) begin
                waiting <= 1'b1;
                count   <= loadVal;
            end else if (waiting && (count != '0)) begin
                count <= count - cw'(1);
            end
        end
    end

    // One-cycle pulses, CIA path is not registered
    assign tackN = !(ackQ || ciaHit);
    assign teaN  = !errQ;
    assign done  = ackQ || errQ || ciaHit;

endmodule

`default_nettype wire

// File: logic/ciaClock.sv
`timescale 1ns/100ps
`default_nettype none

module ciaClock #(
    parameter int ciaHigh = timingPkg::ciaHighDef,
    parameter int ciaLow  = timingPkg::ciaLowDef
) (
    input  logic clk40,
    input  logic rstN,
    output logic ciaClk,
    output logic ciaStrobe
);

    localparam int cw = timingPkg::cntW;

    // Cycles spent in the current phase
    logic [cw-1:0] phaseCnt;
    // Final cycle of whichever phase runs now
    logic          lastCycle;

    //////////////////////////////////////////////////////////////////////
    // E-clock phase counter
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (ciaClk) begin
            lastCycle = phaseCnt == cw'(ciaHigh - 1);
        end else begin
            lastCycle = phaseCnt == cw'(ciaLow - 1);
        end
    end

    always_ff @(posedge clk40) begin
        if (!rstN) begin
            // Start in the low phase
            ciaClk   <= 1'b0;
            phaseCnt <= '0;
        end else if (lastCycle) begin
            // Flip phase and restart the count
            ciaClk   <= !ciaClk;
            phaseCnt <= '0;
        end else begin
            phaseCnt <= phaseCnt + cw'(1);
        end
    end

    // CIA latches data at the end of the high phase
    // Ack for a CIA access goes out here
    assign ciaStrobe = ciaClk && lastCycle;

endmodule

`default_nettype wire

// File: logic/tickGen.sv
`timescale 1ns/100ps
`default_nettype none

module tickGen #(
    parameter int tick60Half = timingPkg::tick60Def,
    parameter int tick50Half = timingPkg::tick50Def
) (
    input  logic clk40,
    input  logic rstN,
    output logic tick60,
    output logic tick50
);

    localparam int tw = timingPkg::tickW;

    // Index 0 is the 60 Hz tick, index 1 the 50 Hz tick
    localparam int halfLen [2] = '{tick60Half, tick50Half};

    logic [tw-1:0] cnt [2];
    logic [1:0]    tickQ;

    // Both dividers share one body
    always_ff @(posedge clk40) begin
        for (int i = 0; i < 2; i++) begin
            if (!rstN) begin
                cnt[i]   <= '0;
                tickQ[i] <= 1'b0;
            end else if (cnt[i] == tw'(halfLen[i] - 1)) begin
                // Half-period done, toggle
                cnt[i]   <= '0;
                tickQ[i] <= !tickQ[i];
            end else begin
                cnt[i] <= cnt[i] + tw'(1);
            end
        end
    end

    // Square waves for the CIA TOD inputs
    assign tick60 = tickQ[0];
    assign tick50 = tickQ[1];

endmodule

`default_nettype wire

// File: logic/glueTop.sv
`timescale 1ns/100ps
`default_nettype none

module glueTop #(
    parameter int romWait    = timingPkg::romWaitDef,
    parameter int chipWait   = timingPkg::chipWaitDef,
    parameter int busTimeout = timingPkg::busTimeoutDef,
    parameter int ciaHigh    = timingPkg::ciaHighDef,
    parameter int ciaLow     = timingPkg::ciaLowDef,
    parameter int tick60Half = timingPkg::tick60Def,
    parameter int tick50Half = timingPkg::tick50Def
) (
    input  logic                   clk40,
    input  logic                   rstN,
    input  logic                   tsN,
    input  logic [busPkg::addrW:1] a,
    input  logic [1:0]             tt,
    input  logic                   lbenN,
    input  logic                   ovl,
    output logic                   tackN,
    output logic                   teaN,
    output logic                   romEnN,
    output logic                   ramSpaceN,
    output logic                   regSpaceN,
    output logic                   ciaCs0N,
    output logic                   ciaCs1N,
    output logic                   bufEnN,
    output logic                   portSize,
    output logic                   ciaClk,
    output logic                   tick60,
    output logic                   tick50
);

    // Decode to ack handoff
    busPkg::spaceT space;
    logic          cycleActive;
    // Cycle finished, selects drop next edge
    logic          done;
    // Last high E-clock cycle
    logic          ciaStrobe;

    //////////////////////////////////////////////////////////////////////
    // Address decode and acknowledge
    //////////////////////////////////////////////////////////////////////

    addressDecode addrDec (
        .clk40       (clk40),
        .rstN        (rstN),
        .tsN         (tsN),
        .a           (a),
        .tt          (tt),
        .lbenN       (lbenN),
        .ovl         (ovl),
        .done        (done),
        .space       (space),
        .cycleActive (cycleActive),
        .romEnN      (romEnN),
        .ramSpaceN   (ramSpaceN),
        .regSpaceN   (regSpaceN),
        .ciaCs0N     (ciaCs0N),
        .ciaCs1N     (ciaCs1N),
        .bufEnN      (bufEnN),
        .portSize    (portSize)
    );

    transferAck #(
        .romWait    (romWait),
        .chipWait   (chipWait),
        .busTimeout (busTimeout)
    ) ackGen (
        .clk40       (clk40),
        .rstN        (rstN),
        .space       (space),
        .cycleActive (cycleActive),
        .ciaStrobe   (ciaStrobe),
        .tackN       (tackN),
        .teaN        (teaN),
        .done        (done)
    );

    //////////////////////////////////////////////////////////////////////
    // Clock dividers
    //////////////////////////////////////////////////////////////////////

    ciaClock #(
        .ciaHigh (ciaHigh),
        .ciaLow  (ciaLow)
    ) eClkGen (
        .clk40     (clk40),
        .rstN      (rstN),
        .ciaClk    (ciaClk),
        .ciaStrobe (ciaStrobe)
    );

    // Free running, not tied to bus cycles
    tickGen #(
        .tick60Half (tick60Half),
        .tick50Half (tick50Half)
    ) ticks (
        .clk40  (clk40),
        .rstN   (rstN),
        .tick60 (tick60),
        .tick50 (tick50)
    );

endmodule

`default_nettype wire

// File: test/tbGlue.sv
`timescale 1ns/100ps
`default_nettype none

module tbGlue;

    //////////////////////////////////////////////////////////////////////
    // Timing parameters handed to the DUT
    //////////////////////////////////////////////////////////////////////

    localparam int romWait    = 3;
    localparam int chipWait   = 5;
    localparam int busTimeout = 64;
    localparam int ciaHigh    = 4;
    localparam int ciaLow     = 6;
    localparam int tick60Half = 7;
    localparam int tick50Half = 9;
    // Loop guards in cycles
    localparam int waitLimit  = busTimeout + 16;
    localparam int runLimit   = 32;
    localparam logic [31:0] rngSeed = 32'h124f01a6;
    // Selects order is romEnN ramSpaceN regSpaceN ciaCs0N ciaCs1N bufEnN portSize
    localparam logic [6:0] selIdle = 7'b1111110;

    logic        clk40;
    logic        rstN;
    logic        tsN;
    logic [31:1] a;
    logic [1:0]  tt;
    logic        lbenN;
    logic        ovl;
    logic        tackN;
    logic        teaN;
    logic        romEnN;
    logic        ramSpaceN;
    logic        regSpaceN;
    logic        ciaCs0N;
    logic        ciaCs1N;
    logic        bufEnN;
    logic        portSize;
    logic        ciaClk;
    logic        tick60;
    logic        tick50;

    glueTop #(
        .romWait    (romWait),
        .chipWait   (chipWait),
        .busTimeout (busTimeout),
        .ciaHigh    (ciaHigh),
        .ciaLow     (ciaLow),
        .tick60Half (tick60Half),
        .tick50Half (tick50Half)
    ) dut (
        .clk40     (clk40),
        .rstN      (rstN),
        .tsN       (tsN),
        .a         (a),
        .tt        (tt),
        .lbenN     (lbenN),
        .ovl       (ovl),
        .tackN     (tackN),
        .teaN      (teaN),
        .romEnN    (romEnN),
        .ramSpaceN (ramSpaceN),
        .regSpaceN (regSpaceN),
        .ciaCs0N   (ciaCs0N),
        .ciaCs1N   (ciaCs1N),
        .bufEnN    (bufEnN),
        .portSize  (portSize),
        .ciaClk    (ciaClk),
        .tick60    (tick60),
        .tick50    (tick50)
    );

    // 100 ns clock
    initial begin
        clk40 = 1'b0;
        forever #50 clk40 = ~clk40;
    end

    //////////////////////////////////////////////////////////////////////
    // Failure reporting
    //////////////////////////////////////////////////////////////////////

    task automatic abortRun();
        $display("Errors found");
        $fatal(1, "Simulation stopped at first failure");
    endtask

    task automatic valueMismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        $display("Error at %0t: %s expected %0h, actual %0h", $time, name, exp, act);
        abortRun();
    endtask

    task automatic reportFault(input string why);
        $display("%s at %0t", why, $time);
        abortRun();
    endtask

    task automatic expectBit(input string name, input logic exp, input logic act);
        assert (act === exp) else valueMismatch(name, {31'b0, exp}, {31'b0, act});
    endtask

    task automatic compareSelects(input logic [6:0] exp);
        expectBit("romEnN", exp[6], romEnN);
        expectBit("ramSpaceN", exp[5], ramSpaceN);
        expectBit("regSpaceN", exp[4], regSpaceN);
        expectBit("ciaCs0N", exp[3], ciaCs0N);
        expectBit("ciaCs1N", exp[2], ciaCs1N);
        expectBit("bufEnN", exp[1], bufEnN);
        expectBit("portSize", exp[0], portSize);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Expected values from the address map
    //////////////////////////////////////////////////////////////////////

    function automatic logic [6:0] selectsFor(input busPkg::spaceT sp, input logic [31:0] addr);
        logic [6:0] sel;
        sel = selIdle;
        case (sp)
            busPkg::spRom:  sel = 7'b0111110;
            busPkg::spChip: sel = 7'b1011100;
            busPkg::spReg:  sel = 7'b1101101;
            busPkg::spCia: begin
                // Narrow port, chip selects follow A12 and A13
                sel    = 7'b1111111;
                sel[3] = addr[12];
                sel[2] = addr[13];
            end
            default:        sel = selIdle;
        endcase
        return sel;
    endfunction

    // Fixed ack cycle counted from the strobe cycle
    function automatic int latencyFor(input busPkg::spaceT sp);
        case (sp)
            busPkg::spAvec: return 2;
            busPkg::spRom:  return 1 + romWait + 1;
            busPkg::spChip: return 1 + chipWait + 1;
            busPkg::spReg:  return 1 + chipWait + 1;
            busPkg::spNone: return 1 + busTimeout;
            default:        return 0;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // One bus transfer started on a falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic runTransfer(input logic [31:0] addr, input logic [1:0] ttv,
                               input logic ovlv, input logic lbv, input busPkg::spaceT sp);
        logic [6:0] expSel;
        int         cyc;
        expSel = selectsFor(sp, addr);
        // Cycle 0 drives the strobe and address
        tsN   = 1'b0;
        a     = addr[31:1];
        tt    = ttv;
        ovl   = ovlv;
        lbenN = lbv;
        @(negedge clk40);
        tsN = 1'b1;
        cyc = 1;
        // Selects hold until the ack
        while (tackN && teaN) begin
            compareSelects(expSel);
            if (cyc > waitLimit) begin
                reportFault("Timeout waiting for tackN or teaN");
            end
            @(negedge clk40);
            cyc++;
        end
        compareSelects(expSel);
        if (sp == busPkg::spNone) begin
            expectBit("teaN", 1'b0, teaN);
            expectBit("tackN", 1'b1, tackN);
        end else begin
            expectBit("tackN", 1'b0, tackN);
            expectBit("teaN", 1'b1, teaN);
        end
        if (sp == busPkg::spCia) begin
            // Ack waits out the holdoff and lands on an E-clock strobe
            assert (cyc >= 3) else reportFault("CIA acknowledge came before the holdoff");
            assert (cyc <= 2 + ciaHigh + ciaLow) else reportFault("CIA acknowledge came late");
            expectBit("ciaClk", 1'b1, ciaClk);
        end else begin
            assert (cyc == latencyFor(sp)) else valueMismatch("ack latency", latencyFor(sp), cyc);
        end
        @(negedge clk40);
        // Single-cycle pulse and release
        expectBit("tackN", 1'b1, tackN);
        expectBit("teaN", 1'b1, teaN);
        compareSelects(selIdle);
        if (sp == busPkg::spCia) begin
            expectBit("ciaClk", 1'b0, ciaClk);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Divider run lengths
    //////////////////////////////////////////////////////////////////////

    function automatic logic signalAt(input int idx);
        case (idx)
            0:       return ciaClk;
            1:       return tick60;
            default: return tick50;
        endcase
    endfunction

    task automatic measureRun(input int idx, input logic lvl, input int expLen, input string name);
        int n;
        int guard;
        // Skip any partial run and align to a fresh one
        guard = 0;
        while (signalAt(idx) == lvl) begin
            guard++;
            if (guard > runLimit) reportFault({"No change seen on ", name});
            @(negedge clk40);
        end
        guard = 0;
        while (signalAt(idx) != lvl) begin
            guard++;
            if (guard > runLimit) reportFault({"No change seen on ", name});
            @(negedge clk40);
        end
        n = 0;
        while (signalAt(idx) == lvl) begin
            n++;
            if (n > runLimit) reportFault({"Run too long on ", name});
            @(negedge clk40);
        end
        assert (n == expLen) else valueMismatch({name, " run length"}, expLen, n);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int               fd;
        int               fields;
        int               count;
        int               gap;
        logic [8*160-1:0] line;
        logic [31:0]      addrV;
        logic [31:0]      ttV;
        logic [31:0]      ovlV;
        logic [31:0]      lbV;
        logic [31:0]      spV;
        rstN  = 1'b0;
        tsN   = 1'b1;
        a     = '0;
        tt    = '0;
        lbenN = 1'b0;
        ovl   = 1'b0;
        count = 0;
        void'($urandom(rngSeed));
        repeat (4) @(negedge clk40);
        // Reset levels
        expectBit("tackN", 1'b1, tackN);
        expectBit("teaN", 1'b1, teaN);
        compareSelects(selIdle);
        expectBit("ciaClk", 1'b0, ciaClk);
        expectBit("tick60", 1'b0, tick60);
        expectBit("tick50", 1'b0, tick50);
        rstN = 1'b1;
        @(negedge clk40);

        fd = $fopen("test/glueGolden.mem", "r");
        if (fd == 0) reportFault("Cannot open test/glueGolden.mem");
        while ($fgets(line, fd) != 0) begin
            fields = $sscanf(line, "%h %h %h %h %h", addrV, ttV, ovlV, lbV, spV);
            // Only full data lines count
            if (fields == 5) begin
                runTransfer(addrV, ttV[1:0], ovlV[0], lbV[0], busPkg::spaceT'(spV[2:0]));
                count++;
                // Idle gap moves the E-clock phase
                gap = $urandom % 5;
                repeat (gap) @(negedge clk40);
            end
        end
        $fclose(fd);
        if (count == 0) reportFault("No transfers read from the golden file");

        measureRun(0, 1'b1, ciaHigh, "ciaClk");
        measureRun(0, 1'b0, ciaLow, "ciaClk");
        measureRun(1, 1'b1, tick60Half, "tick60");
        measureRun(1, 1'b0, tick60Half, "tick60");
        measureRun(2, 1'b1, tick50Half, "tick50");
        measureRun(2, 1'b0, tick50Half, "tick50");

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/glueGolden.mem
// Columns: byte address, tt, ovl, lbenN, expected space (all hex)
// Space codes: 0 none, 1 chip, 2 reg, 3 cia, 4 rom, 5 autovector
00001000 0 0 0 1
00001000 0 1 0 4
00100000 0 1 0 1
00dff096 0 0 0 2
00bfe001 0 0 0 3
00bfd000 0 0 0 3
00f80000 0 0 0 4
00fc1234 0 0 0 4
00001000 3 0 0 5
00e00000 0 0 0 0
01000000 0 0 0 0
00dff000 0 0 1 0

// File: tb.f
common/busPkg.sv
common/timingPkg.sv
decode/addressDecode.sv
logic/transferAck.sv
logic/ciaClock.sv
logic/tickGen.sv
logic/glueTop.sv
test/tbGlue.sv

// File: Makefile
# Verilator build and run for the bus glue testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tbGlue, check $(LOG) for a pass"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tbGlue -f tb.f -o tbGlue --Mdir obj_dir
	./obj_dir/tbGlue | tee $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
